// ==== include/nes_loader_consts.svh ====
/*
 * Cartridge loader constants
 * Bus widths, header signatures, memory map and run-slot phase
 */
`ifndef NES_LOADER_CONSTS_SVH
`define NES_LOADER_CONSTS_SVH

`define NES_ADDR_W 22 // Byte address into cartridge memory
`define NES_BYTE_W 8
`define HDR_BYTES 16
`define FLAGS_W 32

// First file byte sits in the top byte
`define MAGIC_INES 32'h4E45_531A // "NES" 1A
`define MAGIC_FDS 32'h4644_531A // "FDS" 1A

// Memory map of the loaded image
`define PRG_BASE 22'h000000
`define CHR_BASE 22'h200000
`define FDS_BASE 22'h040010 // Disk data lands past the header slot

`define PRG_PAGE_SHIFT 14 // 16 KiB pages
`define CHR_PAGE_SHIFT 13 // 8 KiB pages

// Console runs on one cycle out of four
`define RUN_PHASE 2'd3

`endif

// ==== hw/nes_loader_pkg.sv ====
/*
 * Shared types of the cartridge loader
 * Header word with raw and field views, loader kind and mapper-flag word
 */
`include "nes_loader_consts.svh"

package nes_loader_pkg;

	// Header fields in file order with byte 0 at the top
	typedef struct packed {
		logic [31:0] magic;
		logic [7:0] prg_pages; // 16 KiB units
		logic [7:0] chr_pages; // 8 KiB units, zero means CHR RAM
		logic [7:0] flags6;
		logic [7:0] flags7;
		logic [7:0] mapper_hi; // iNES 2.0 mapper extension
		logic [55:0] tail;
	} ines_fields_t;

	// Same 128 bits seen as bytes by capture and as fields by decode
	typedef union packed {
		logic [0:`HDR_BYTES-1][`NES_BYTE_W-1:0] raw;
		ines_fields_t fields;
	} ines_header_u;

	typedef enum logic [1:0] {
		KIND_INES,
		KIND_FDS,
		KIND_BAD
	} load_kind_e;

	// Word handed to the console core
	typedef struct packed {
		logic [`FLAGS_W-26:0] reserved; // Always zero
		logic [7:0] nes2_mapper;
		logic four_screen;
		logic chr_ram;
		logic mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage

// ==== hw/ines_header_capture.sv ====
`timescale 1ns/1ps
/*
 * Header capture stage
 * Collects the first 16 bytes of a download and passes the rest on as payload
 */
`include "nes_loader_consts.svh"

module ines_header_capture (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic [`NES_BYTE_W-1:0] byte_in,
	input logic byte_strobe,
	output nes_loader_pkg::ines_header_u header,
	output logic header_valid,
	output logic [`NES_BYTE_W-1:0] payload_byte,
	output logic payload_strobe
);
	localparam int IDX_W = $clog2(`HDR_BYTES);

	logic downloading_q;
	logic download_start;
	logic [IDX_W-1:0] byte_idx;
	logic header_full; // All header bytes seen

	assign download_start = downloading & ~downloading_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			downloading_q <= 1'b0;
			byte_idx <= '0;
			header_full <= 1'b0;
			header_valid <= 1'b0;
			payload_strobe <= 1'b0;
		end else begin
			downloading_q <= downloading;
			header_valid <= 1'b0;
			payload_strobe <= 1'b0;
			if (download_start) begin
				byte_idx <= '0; // New file
				header_full <= 1'b0;
			end else if (byte_strobe) begin
				if (header_full) begin
					payload_strobe <= 1'b1;
				end else begin
					byte_idx <= byte_idx + 1'b1;
					if (byte_idx == IDX_W'(`HDR_BYTES - 1)) begin
						header_full <= 1'b1;
						header_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_strobe && !header_full && !download_start) begin
			header.raw[byte_idx] <= byte_in;
		end
		if (byte_strobe) begin
			payload_byte <= byte_in; // Only qualified by payload_strobe
		end
	end

endmodule

// ==== hw/ines_header_decode.sv ====
`timescale 1ns/1ps
/*
 * Header decode stage
 * Classifies the captured header and builds the mapper-flag word and region lengths
 */
`include "nes_loader_consts.svh"

module ines_header_decode (
	input logic clk,
	input logic reset,
	input logic invert_mirroring,
	input nes_loader_pkg::ines_header_u header,
	input logic header_valid,
	output nes_loader_pkg::load_kind_e kind,
	output nes_loader_pkg::mapper_flags_t flags,
	output logic [`NES_ADDR_W-1:0] prg_len,
	output logic [`NES_ADDR_W-1:0] chr_len,
	output logic decode_valid
);
	import nes_loader_pkg::*;

	localparam int ADDR_W = `NES_ADDR_W;

	ines_fields_t hdr; // Fields after FDS substitution
	logic is_ines;
	logic is_fds;
	logic is_nes20;
	logic is_dirty;
	load_kind_e kind_d;
	mapper_flags_t flags_d;

	// Ceiling log2 of the page count with saturation at 7
	// 0 and 1 pages both give 0
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (pages > (8'd1 << i))
				code = 3'(i + 1);
		end
		return code;
	endfunction

	// Trainers are not supported
	assign is_ines = (header.fields.magic == `MAGIC_INES) && !header.fields.flags6[2];
	assign is_fds = (header.fields.magic == `MAGIC_FDS);

	always_comb begin
		hdr = header.fields;
		if (is_fds) begin
			// Disk images run on a fixed profile as mapper 20 with CHR RAM
			hdr.prg_pages = 8'hFF;
			hdr.chr_pages = 8'h00;
			hdr.flags6 = 8'h40;
			hdr.flags7 = 8'h10;
			hdr.mapper_hi = 8'h00;
			hdr.tail = '0;
		end
	end

	assign is_nes20 = (hdr.flags7[3:2] == 2'b10);
	assign is_dirty = !is_nes20 && ((hdr.mapper_hi[7:1] != '0) || (hdr.tail != '0));

	assign kind_d = is_ines ? KIND_INES : (is_fds ? KIND_FDS : KIND_BAD);

	always_comb begin
		flags_d.reserved = '0;
		flags_d.nes2_mapper = is_nes20 ? hdr.mapper_hi : 8'h00;
		flags_d.four_screen = hdr.flags6[3];
		flags_d.chr_ram = (hdr.chr_pages == 8'h00);
		flags_d.mirroring = hdr.flags6[0] ^ invert_mirroring;
		flags_d.chr_size = size_code(hdr.chr_pages);
		flags_d.prg_size = size_code(hdr.prg_pages);
		// Junk in flags7 on dirty dumps
		flags_d.mapper = {is_dirty ? 4'h0 : hdr.flags7[7:4], hdr.flags6[7:4]};
	end

	always_ff @(posedge clk) begin
		if (reset)
			decode_valid <= 1'b0;
		else
			decode_valid <= header_valid;
	end

	always_ff @(posedge clk) begin
		if (header_valid) begin
			kind <= kind_d;
			flags <= flags_d;
			prg_len <= ADDR_W'(header.fields.prg_pages) << `PRG_PAGE_SHIFT;
			chr_len <= ADDR_W'(header.fields.chr_pages) << `CHR_PAGE_SHIFT;
		end
	end

endmodule

// ==== hw/rom_address_gen.sv ====
`timescale 1ns/1ps
/*
 * Address generation stage
 * Steps through the PRG, CHR or FDS region and issues one write per payload byte
 */
`include "nes_loader_consts.svh"

module rom_address_gen (
	input logic clk,
	input logic reset,
	input logic downloading,
	input nes_loader_pkg::load_kind_e kind,
	input nes_loader_pkg::mapper_flags_t flags,
	input logic [`NES_ADDR_W-1:0] prg_len,
	input logic [`NES_ADDR_W-1:0] chr_len,
	input logic decode_valid,
	input logic [`NES_BYTE_W-1:0] payload_byte,
	input logic payload_strobe,
	output logic [`NES_ADDR_W-1:0] wr_addr,
	output logic [`NES_BYTE_W-1:0] wr_data,
	output logic wr_req,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic done,
	output logic error
);
	import nes_loader_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PRG,
		ST_CHR,
		ST_FDS,
		ST_DONE,
		ST_ERROR
	} state_e;

	state_e state;
	logic downloading_q;
	logic [`NES_ADDR_W-1:0] addr; // Next write address
	logic [`NES_ADDR_W-1:0] remaining; // Bytes left in the current region
	logic take_byte;

	// Bytes past the end of a PRG or CHR region are dropped
	always_comb begin
		case (state)
			ST_PRG, ST_CHR: take_byte = payload_strobe && (remaining != '0);
			ST_FDS: take_byte = payload_strobe;
			default: take_byte = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			downloading_q <= 1'b0;
			addr <= '0;
			remaining <= '0;
			wr_req <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			downloading_q <= downloading;
			wr_req <= take_byte;
			if (downloading && !downloading_q) begin
				state <= ST_IDLE;
				done <= 1'b0;
				error <= 1'b0;
			end else if (decode_valid) begin
				case (kind)
					KIND_INES: begin
						state <= ST_PRG;
						addr <= `PRG_BASE;
						remaining <= prg_len;
					end
					KIND_FDS: begin
						state <= ST_FDS;
						addr <= `FDS_BASE;
					end
					default: begin
						state <= ST_ERROR;
						done <= 1'b1;
						error <= 1'b1;
					end
				endcase
			end else begin
				if (take_byte) begin
					addr <= addr + 1'b1;
					remaining <= remaining - 1'b1;
				end
				case (state)
					ST_PRG: begin
						if (remaining == '0) begin
							addr <= `CHR_BASE;
							remaining <= chr_len;
							if (chr_len == '0) begin
								state <= ST_DONE; // CHR RAM cart
								done <= 1'b1;
							end else begin
								state <= ST_CHR;
							end
						end
					end
					ST_CHR: begin
						if (remaining == '0) begin
							state <= ST_DONE;
							done <= 1'b1;
						end
					end
					ST_FDS: begin
						if (!downloading) begin
							state <= ST_DONE; // Disk size is only known from the transfer
							done <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_byte) begin
			wr_addr <= addr;
			wr_data <= payload_byte;
		end
		if (decode_valid) begin
			mapper_flags <= flags;
		end
	end

endmodule

// ==== hw/mem_write_pacer.sv ====
`timescale 1ns/1ps
/*
 * Write pacer
 * Holds one loader write and releases it in the console run slot
 */
`include "nes_loader_consts.svh"

module mem_write_pacer (
	input logic clk,
	input logic reset,
	input logic [`NES_ADDR_W-1:0] wr_addr,
	input logic [`NES_BYTE_W-1:0] wr_data,
	input logic wr_req,
	output logic [`NES_ADDR_W-1:0] mem_addr,
	output logic [`NES_BYTE_W-1:0] mem_data,
	output logic mem_write,
	output logic run_ce
);
	logic [1:0] phase; // Free-running slot counter
	logic pending; // A write waits for the slot

	assign run_ce = (phase == `RUN_PHASE);
	assign mem_write = pending & run_ce;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 2'd0;
			pending <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			if (wr_req)
				pending <= 1'b1;
			else if (mem_write)
				pending <= 1'b0;
		end
	end

	// Input spacing keeps at most one write in flight
	always_ff @(posedge clk) begin
		if (wr_req) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

endmodule

// ==== hw/nes_loader_top.sv ====
`timescale 1ns/1ps
/*
 * Cartridge loader top level
 * Capture, decode, address generation and write pacing in pipeline order
 */
`include "nes_loader_consts.svh"

module nes_loader_top (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic [`NES_BYTE_W-1:0] byte_in,
	input logic byte_strobe,
	input logic invert_mirroring,
	output logic [`NES_ADDR_W-1:0] mem_addr,
	output logic [`NES_BYTE_W-1:0] mem_data,
	output logic mem_write,
	output logic run_ce,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic done,
	output logic error
);
	import nes_loader_pkg::*;

	ines_header_u header;
	logic header_valid;
	logic [`NES_BYTE_W-1:0] payload_byte;
	logic payload_strobe;
	load_kind_e kind;
	mapper_flags_t flags;
	logic [`NES_ADDR_W-1:0] prg_len;
	logic [`NES_ADDR_W-1:0] chr_len;
	logic decode_valid;
	logic [`NES_ADDR_W-1:0] wr_addr;
	logic [`NES_BYTE_W-1:0] wr_data;
	logic wr_req;

	ines_header_capture u_capture (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.byte_in(byte_in),
		.byte_strobe(byte_strobe),
		.header(header),
		.header_valid(header_valid),
		.payload_byte(payload_byte),
		.payload_strobe(payload_strobe)
	);

	ines_header_decode u_decode (
		.clk(clk),
		.reset(reset),
		.invert_mirroring(invert_mirroring),
		.header(header),
		.header_valid(header_valid),
		.kind(kind),
		.flags(flags),
		.prg_len(prg_len),
		.chr_len(chr_len),
		.decode_valid(decode_valid)
	);

	rom_address_gen u_addr_gen (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.kind(kind),
		.flags(flags),
		.prg_len(prg_len),
		.chr_len(chr_len),
		.decode_valid(decode_valid),
		.payload_byte(payload_byte),
		.payload_strobe(payload_strobe),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_req(wr_req),
		.mapper_flags(mapper_flags),
		.done(done),
		.error(error)
	);

	mem_write_pacer u_pacer (
		.clk(clk),
		.reset(reset),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_req(wr_req),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_write(mem_write),
		.run_ce(run_ce)
	);

endmodule

// ==== bench/tb_nes_loader.sv ====
`timescale 1ns/1ps
/*
 * Cartridge loader testbench
 * Directed iNES, FDS and broken-header loads with write, flag and run-slot checks
 */
`include "nes_loader_consts.svh"

module tb_nes_loader;
	logic clk;
	logic reset;
	logic downloading;
	logic [7:0] byte_in;
	logic byte_strobe;
	logic invert_mirroring;
	logic [21:0] mem_addr;
	logic [7:0] mem_data;
	logic mem_write;
	logic run_ce;
	logic [31:0] mapper_flags;
	logic done;
	logic error;

	logic [15:0] lfsr; // Payload generator state
	logic [21:0] got_addr_q[$];
	logic [7:0] got_data_q[$];
	logic [21:0] exp_addr_q[$];
	logic [7:0] exp_data_q[$];
	int errors;
	int timeouts;
	int unslotted_writes; // mem_write outside the run slot
	int payload_sent;

	nes_loader_top DUT (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.byte_in(byte_in),
		.byte_strobe(byte_strobe),
		.invert_mirroring(invert_mirroring),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_write(mem_write),
		.run_ce(run_ce),
		.mapper_flags(mapper_flags),
		.done(done),
		.error(error)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	function automatic logic [127:0] header_word(input logic [31:0] magic,
		input logic [7:0] prg, input logic [7:0] chr, input logic [7:0] f6,
		input logic [7:0] f7, input logic [7:0] mhi, input logic [55:0] tail);
		return {magic, prg, chr, f6, f7, mhi, tail};
	endfunction

	function automatic logic [31:0] pack_flags(input logic [7:0] nes2,
		input logic four_screen, input logic chr_ram, input logic mirroring,
		input logic [2:0] chr_size, input logic [2:0] prg_size, input logic [7:0] mapper);
		return {7'd0, nes2, four_screen, chr_ram, mirroring, chr_size, prg_size, mapper};
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("FAIL %s expected %h got %h", name, exp, act);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR %s", what);
	endtask

	// One strobe every 6 cycles
	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		byte_in <= b;
		byte_strobe <= 1'b1;
		@(posedge clk);
		byte_strobe <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic send_header(input logic [127:0] h);
		logic [127:0] word;
		word = h;
		for (int i = 0; i < 16; i++) begin
			send_byte(word[127:120]); // File order, magic first
			word = word << 8;
		end
	endtask

	task automatic send_payload(input int count, input logic [21:0] base);
		logic [7:0] b;
		for (int n = 0; n < count; n++) begin
			for (int i = 0; i < 8; i++) begin
				b = {lfsr[0], b[7:1]};
				lfsr = lfsr_step(lfsr);
			end
			exp_addr_q.push_back(base + 22'(n));
			exp_data_q.push_back(b);
			send_byte(b);
		end
		payload_sent += count;
	endtask

	// Bytes the loader has to drop
	task automatic send_extra(input int count);
		for (int n = 0; n < count; n++)
			send_byte(8'hEE);
	endtask

	task automatic start_download(input logic inv);
		got_addr_q.delete();
		got_data_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		@(posedge clk);
		downloading <= 1'b1;
		invert_mirroring <= inv;
		repeat (3) @(posedge clk); // Capture restarts before the first byte
	endtask

	task automatic end_download();
		@(posedge clk);
		downloading <= 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		cycles = 0;
		while (!done && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			timeouts++;
			$display("ERROR timed out waiting for done");
		end
	endtask

	task automatic wait_writes(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (got_addr_q.size() < count && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (got_addr_q.size() < count) begin
			timeouts++;
			$display("ERROR timed out waiting for memory writes");
		end
	endtask

	task automatic compare_writes();
		if (got_addr_q.size() != exp_addr_q.size())
			report_value("write count", 32'(exp_addr_q.size()), 32'(got_addr_q.size()));
		for (int i = 0; i < exp_addr_q.size() && i < got_addr_q.size(); i++) begin
			if (got_addr_q[i] !== exp_addr_q[i])
				report_value("mem_addr", 32'(exp_addr_q[i]), 32'(got_addr_q[i]));
			if (got_data_q[i] !== exp_data_q[i])
				report_value("mem_data", 32'(exp_data_q[i]), 32'(got_data_q[i]));
		end
	endtask

	task automatic test_ines_load();
		start_download(1'b0);
		send_header(header_word(`MAGIC_INES, 8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 56'd0));
		send_payload(16384, `PRG_BASE);
		send_payload(8192, `CHR_BASE);
		wait_done(100);
		if (error !== 1'b0)
			report_value("error", 32'd0, 32'(error));
		if (mapper_flags !== pack_flags(8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00))
			report_value("mapper_flags", 32'd0, mapper_flags);
		wait_writes(exp_addr_q.size(), 50);
		send_extra(2); // Past the CHR region
		end_download();
		compare_writes();
	endtask

	task automatic test_flag_decode();
		logic [31:0] exp;
		start_download(1'b1);
		send_header(header_word(`MAGIC_INES, 8'd4, 8'd0, 8'h11, 8'h28, 8'h05, 56'd0));
		// Flags are latched three cycles after the last header strobe
		@(negedge clk);
		exp = pack_flags(8'h05, 1'b0, 1'b1, 1'b0, 3'd0, 3'd2, 8'h21);
		if (mapper_flags !== exp)
			report_value("mapper_flags", exp, mapper_flags);
		end_download();

		// Dumper signature in the tail marks the header dirty
		start_download(1'b0);
		send_header(header_word(`MAGIC_INES, 8'd2, 8'd1, 8'h10, 8'h30, 8'h00,
			56'h44_6973_6B44_7564));
		@(negedge clk);
		exp = pack_flags(8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd1, 8'h01);
		if (mapper_flags !== exp)
			report_value("mapper_flags", exp, mapper_flags);
		end_download();
	endtask

	task automatic check_rejected(input logic [127:0] h);
		start_download(1'b0);
		send_header(h);
		wait_done(50);
		if (error !== 1'b1)
			report_value("error", 32'd1, 32'(error));
		send_extra(4);
		end_download();
		if (got_addr_q.size() != 0)
			report_value("write count", 32'd0, 32'(got_addr_q.size()));
	endtask

	task automatic test_bad_header();
		check_rejected(header_word(32'h4E45_5800, 8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 56'd0));
		check_rejected(header_word(`MAGIC_INES, 8'd1, 8'd1, 8'h04, 8'h00, 8'h00, 56'd0));
	endtask

	task automatic test_fds_load();
		logic [31:0] exp;
		start_download(1'b1);
		send_header(header_word(`MAGIC_FDS, 8'd1, 8'd0, 8'h00, 8'h00, 8'h00, 56'd0));
		send_payload(32, `FDS_BASE);
		wait_writes(32, 50);
		if (done !== 1'b0)
			report_value("done", 32'd0, 32'(done)); // Disk still streaming
		end_download();
		wait_done(20);
		if (error !== 1'b0)
			report_value("error", 32'd0, 32'(error));
		exp = pack_flags(8'h00, 1'b0, 1'b1, 1'b1, 3'd0, 3'd7, 8'd20);
		if (mapper_flags !== exp)
			report_value("mapper_flags", exp, mapper_flags);
		compare_writes();
	endtask

	task automatic test_run_slot();
		int ce_count;
		ce_count = 0;
		for (int i = 0; i < 40; i++) begin
			@(negedge clk);
			if (run_ce)
				ce_count++;
		end
		if (ce_count != 10)
			report_value("run_ce count", 32'd10, 32'(ce_count));
		payload_sent = 0;
		start_download(1'b0);
		send_header(header_word(`MAGIC_FDS, 8'd1, 8'd0, 8'h00, 8'h00, 8'h00, 56'd0));
		send_payload(24, `FDS_BASE);
		wait_writes(payload_sent, 50);
		end_download();
		wait_done(20);
		if (got_addr_q.size() != payload_sent)
			report_value("write count", 32'(payload_sent), 32'(got_addr_q.size()));
		if (unslotted_writes != 0)
			report_value("unslotted writes", 32'd0, 32'(unslotted_writes));
	endtask

	// Write recorder and run-slot spacing watch
	initial begin : write_monitor
		int since_ce;
		logic seen_ce;
		since_ce = 0;
		seen_ce = 1'b0;
		forever begin
			@(negedge clk);
			if (!reset) begin
				if (mem_write) begin
					got_addr_q.push_back(mem_addr);
					got_data_q.push_back(mem_data);
					if (!run_ce)
						unslotted_writes++;
				end
				since_ce++;
				if (run_ce) begin
					if (seen_ce && since_ce != 4)
						report_problem("run_ce did not repeat every fourth cycle");
					seen_ce = 1'b1;
					since_ce = 0;
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		downloading = 1'b0;
		byte_in = 8'h00;
		byte_strobe = 1'b0;
		invert_mirroring = 1'b0;
		lfsr = 16'd63;
		errors = 0;
		timeouts = 0;
		unslotted_writes = 0;
		payload_sent = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		test_ines_load();
		test_flag_decode();
		test_bad_header();
		test_fds_load();
		test_run_slot();

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
hw/nes_loader_pkg.sv
hw/ines_header_capture.sv
hw/ines_header_decode.sv
hw/rom_address_gen.sv
hw/mem_write_pacer.sv
hw/nes_loader_top.sv
bench/tb_nes_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_nes_loader -f sources.f -o tb_nes_loader; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_nes_loader)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
